//--- hdl/uart_pkg.sv
package uart_pkg;

    // One character on the serial line
    typedef logic [7:0] byte_t;

    // Frame format is 8N1
    localparam int DATA_BITS = 8;

    // Line level between frames and during the stop bit
    localparam logic LINE_IDLE = 1'b1;

    // Line level of the start bit
    localparam logic START_LEVEL = 1'b0;

    // 125 MHz system clock at 115200 baud, rounded to the nearest cycle
    localparam int CLOCKS_PER_BIT_DEFAULT = 1085;

    // Room for a burst of echo traffic, must stay a power of two
    localparam int FIFO_DEPTH_DEFAULT = 256;

endpackage

//--- hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLOCKS_PER_BIT = uart_pkg::CLOCKS_PER_BIT_DEFAULT
) (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_uart_rx,
    output logic            o_valid,
    output uart_pkg::byte_t o_data
);

    localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);

    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLOCKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLOCKS_PER_BIT / 2 - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(uart_pkg::DATA_BITS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t          state;
    logic [CNT_W-1:0] bit_time;
    logic [BIT_W-1:0] bit_cnt;
    uart_pkg::byte_t  shift_reg;

    // Two-flop synchronizer plus one more stage for edge detection
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rx_meta <= uart_pkg::LINE_IDLE;
            rx_sync <= uart_pkg::LINE_IDLE;
            rx_prev <= uart_pkg::LINE_IDLE;
        end else begin
            rx_meta <= i_uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= ST_IDLE;
            bit_time <= '0;
            bit_cnt  <= '0;
            o_valid  <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Falling edge starts the half-bit wait
                    if (rx_prev == uart_pkg::LINE_IDLE &&
                        rx_sync == uart_pkg::START_LEVEL) begin
                        state    <= ST_START;
                        bit_time <= HALF_BIT;
                    end
                end
                ST_START: begin
                    if (bit_time != '0) begin
                        bit_time <= bit_time - 1'b1;
                    end else if (rx_sync == uart_pkg::START_LEVEL) begin
                        state    <= ST_DATA;
                        bit_time <= FULL_BIT;
                        bit_cnt  <= '0;
                    end else begin
                        // Glitch, not a real start bit
                        state <= ST_IDLE;
                    end
                end
                ST_DATA: begin
                    if (bit_time != '0) begin
                        bit_time <= bit_time - 1'b1;
                    end else begin
                        bit_time <= FULL_BIT;
                        if (bit_cnt == LAST_BIT) begin
                            state <= ST_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_STOP: begin
                    if (bit_time != '0) begin
                        bit_time <= bit_time - 1'b1;
                    end else begin
                        // Framing error drops the byte silently
                        o_valid <= (rx_sync == uart_pkg::LINE_IDLE);
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == ST_DATA && bit_time == '0) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    assign o_data = shift_reg;

endmodule

//--- hdl/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = uart_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_valid,
    input  uart_pkg::byte_t i_data,
    output logic            o_valid,
    output uart_pkg::byte_t o_data,
    input  logic            i_ready
);

    localparam int AW = $clog2(FIFO_DEPTH);

    uart_pkg::byte_t mem [FIFO_DEPTH];

    // Extra MSB tells a full memory from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic mem_empty;
    logic mem_full;
    logic out_load;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    assign mem_empty = (wr_ptr == rd_ptr);
    assign mem_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                       (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Output register can take a new byte when empty or being drained
    assign out_load = !o_valid || i_ready;

    // Straight to the output register when nothing is queued ahead
    assign bypass = out_load && mem_empty && i_valid;

    assign mem_wr = i_valid && !mem_full && !bypass;
    assign mem_rd = out_load && !mem_empty;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_load) begin
                o_valid <= mem_rd || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr[AW-1:0]] <= i_data;
        end
    end

    // Held while the consumer stalls
    always_ff @(posedge clk) begin
        if (mem_rd) begin
            o_data <= mem[rd_ptr[AW-1:0]];
        end else if (bypass) begin
            o_data <= i_data;
        end
    end

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLOCKS_PER_BIT = uart_pkg::CLOCKS_PER_BIT_DEFAULT
) (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_valid,
    input  uart_pkg::byte_t i_data,
    output logic            o_ready,
    output logic            o_uart_tx
);

    localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);

    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLOCKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(uart_pkg::DATA_BITS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] bit_time;
    logic [BIT_W-1:0] bit_cnt;
    uart_pkg::byte_t  shift_reg;
    logic             bit_end;
    logic             shift_out;

    assign o_ready = (state == ST_IDLE);
    assign bit_end = (bit_time == '0);

    // Next data bit leaves the shift register at each data-bit boundary
    assign shift_out = bit_end &&
                       ((state == ST_START) ||
                        (state == ST_DATA && bit_cnt != LAST_BIT));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state     <= ST_IDLE;
            bit_time  <= '0;
            bit_cnt   <= '0;
            o_uart_tx <= uart_pkg::LINE_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_valid) begin
                        state     <= ST_START;
                        bit_time  <= FULL_BIT;
                        o_uart_tx <= uart_pkg::START_LEVEL;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        state     <= ST_DATA;
                        bit_time  <= FULL_BIT;
                        bit_cnt   <= '0;
                        o_uart_tx <= shift_reg[0];
                    end else begin
                        bit_time <= bit_time - 1'b1;
                    end
                end
                ST_DATA: begin
                    if (!bit_end) begin
                        bit_time <= bit_time - 1'b1;
                    end else if (bit_cnt == LAST_BIT) begin
                        state     <= ST_STOP;
                        bit_time  <= FULL_BIT;
                        o_uart_tx <= uart_pkg::LINE_IDLE;
                    end else begin
                        bit_time  <= FULL_BIT;
                        bit_cnt   <= bit_cnt + 1'b1;
                        o_uart_tx <= shift_reg[0];
                    end
                end
                ST_STOP: begin
                    if (bit_end) begin
                        state <= ST_IDLE;
                    end else begin
                        bit_time <= bit_time - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            shift_reg <= i_data;
        end else if (shift_out) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

//--- hdl/uart_echo_top.sv
`timescale 1ns/1ps

module uart_echo_top #(
    parameter int CLOCKS_PER_BIT = uart_pkg::CLOCKS_PER_BIT_DEFAULT,
    parameter int FIFO_DEPTH     = uart_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic clk,
    input  logic i_reset,
    input  logic i_uart_rx,
    output logic o_uart_tx
);

    // Receiver to FIFO, no back-pressure
    logic            rx_valid;
    uart_pkg::byte_t rx_data;

    // FIFO to transmitter
    logic            fifo_valid;
    uart_pkg::byte_t fifo_data;
    logic            tx_ready;

    uart_rx #(
        .CLOCKS_PER_BIT (CLOCKS_PER_BIT)
    ) uart_rx0 (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_uart_rx (i_uart_rx),
        .o_valid   (rx_valid),
        .o_data    (rx_data)
    );

    // Bytes are dropped here if the transmitter falls too far behind
    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) byte_fifo0 (
        .clk     (clk),
        .i_reset (i_reset),
        .i_valid (rx_valid),
        .i_data  (rx_data),
        .o_valid (fifo_valid),
        .o_data  (fifo_data),
        .i_ready (tx_ready)
    );

    uart_tx #(
        .CLOCKS_PER_BIT (CLOCKS_PER_BIT)
    ) uart_tx0 (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_valid   (fifo_valid),
        .i_data    (fifo_data),
        .o_ready   (tx_ready),
        .o_uart_tx (o_uart_tx)
    );

endmodule

//--- test/tb_uart_echo.sv
`timescale 1ns/1ps

module tb_uart_echo;

    localparam int BIT_CLKS    = 16;
    localparam int DEPTH       = 8;
    localparam int CLK_PERIOD  = 10;
    localparam int NUM_ENTRIES = 14;

    // Three times the nominal line time of all frames, plus margin
    localparam int WATCHDOG_NS = NUM_ENTRIES * 10 * BIT_CLKS * CLK_PERIOD * 3 + 2000;

    // Quiet time after the last echo, long enough to catch a stray frame
    localparam int SETTLE_CLKS = 2 * 10 * BIT_CLKS;

    typedef struct packed {
        logic [7:0]         data;
        logic               bad_stop;
        logic               expect_echo;
        logic signed [31:0] gap;
    } entry_t;

    logic clk = 1'b0;
    logic i_reset = 1'b1;
    logic i_uart_rx = 1'b1;
    logic o_uart_tx;

    entry_t          stim_table [NUM_ENTRIES];
    uart_pkg::byte_t expected_q [$];
    uart_pkg::byte_t decoded_q [$];

    uart_echo_top #(
        .CLOCKS_PER_BIT (BIT_CLKS),
        .FIFO_DEPTH     (DEPTH)
    ) dut0 (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_uart_rx (i_uart_rx),
        .o_uart_tx (o_uart_tx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got %0h, expected %0h",
                     $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Gap of -1 means a random idle time of 0 to 40 cycles
    task automatic load_table();
        int i;
        // Single byte with a long idle so its echo stands alone
        stim_table[0]  = '{8'hA5, 1'b0, 1'b1, 400};
        // Back-to-back burst that has to queue in the FIFO
        stim_table[1]  = '{8'h00, 1'b0, 1'b1, 0};
        stim_table[2]  = '{8'hFF, 1'b0, 1'b1, 0};
        stim_table[3]  = '{8'h55, 1'b0, 1'b1, 0};
        stim_table[4]  = '{8'h3C, 1'b0, 1'b1, 200};
        // Bad stop bits, each followed by a short high idle
        stim_table[5]  = '{8'hE7, 1'b1, 1'b0, 16};
        stim_table[6]  = '{8'h81, 1'b0, 1'b1, 0};
        stim_table[7]  = '{8'h42, 1'b1, 1'b0, 16};
        stim_table[8]  = '{8'h99, 1'b0, 1'b1, 0};
        // Random spacing
        stim_table[9]  = '{8'h12, 1'b0, 1'b1, -1};
        stim_table[10] = '{8'hC3, 1'b0, 1'b1, -1};
        stim_table[11] = '{8'h7E, 1'b0, 1'b1, -1};
        stim_table[12] = '{8'h01, 1'b0, 1'b1, -1};
        stim_table[13] = '{8'h80, 1'b0, 1'b1, -1};
        for (i = 0; i < NUM_ENTRIES; i++) begin
            if (stim_table[i].expect_echo) begin
                expected_q.push_back(stim_table[i].data);
            end
        end
    endtask

    // Start bit, LSB first data, stop bit; called on a falling clock edge
    task automatic send_frame(input uart_pkg::byte_t data, input logic bad_stop);
        logic [9:0] frame;
        int i;
        frame = {~bad_stop, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            i_uart_rx = frame[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
    endtask

    // Line decoder, samples near the middle of each bit
    initial begin : decoder
        uart_pkg::byte_t data;
        int i;
        wait (i_reset == 1'b0);
        forever begin
            @(negedge o_uart_tx);
            repeat (BIT_CLKS / 2) @(negedge clk);
            check_value("o_uart_tx start bit", o_uart_tx, 1'b0);
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                data[i] = o_uart_tx;
            end
            repeat (BIT_CLKS) @(negedge clk);
            check_value("o_uart_tx stop bit", o_uart_tx, 1'b1);
            decoded_q.push_back(data);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the echo never completed within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main
        int i;
        int gap;
        void'($urandom(32'h9d675853));
        i_reset   = 1'b1;
        i_uart_rx = 1'b1;
        load_table();

        repeat (5) @(negedge clk);
        i_reset = 1'b0;

        // Line must stay idle with nothing received
        for (i = 0; i < 100; i++) begin
            @(negedge clk);
            check_value("o_uart_tx idle", o_uart_tx, 1'b1);
        end

        for (i = 0; i < NUM_ENTRIES; i++) begin
            send_frame(stim_table[i].data, stim_table[i].bad_stop);
            i_uart_rx = 1'b1;
            if (stim_table[i].gap < 0) begin
                gap = $urandom % 41;
            end else begin
                gap = stim_table[i].gap;
            end
            repeat (gap) @(negedge clk);
        end

        while (decoded_q.size() < expected_q.size()) begin
            @(negedge clk);
        end
        repeat (SETTLE_CLKS) @(negedge clk);

        check_value("decoded byte count", decoded_q.size(), expected_q.size());
        for (i = 0; i < expected_q.size(); i++) begin
            check_value($sformatf("echo byte %0d", i), decoded_q[i], expected_q[i]);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- all.f
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_echo_top.sv
test/tb_uart_echo.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the UART echo testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_uart_echo \
    -f all.f \
    --Mdir obj_dir \
    -o sim_uart_echo > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_uart_echo > sim.log 2>&1

cat sim.log

grep -q "^NO ERRORS$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
